// ==== design/interconnect_pkg.sv ====
/* Shared widths and structs for the word-wide request/grant interconnect.
   Addresses are byte addresses; data is always one 32-bit word with byte enables. */

`default_nettype none

package interconnect_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Byte address width seen by masters and slaves
    localparam int unsigned ADDR_WIDTH = 32;
    // One data word per transfer
    localparam int unsigned DATA_WIDTH = 32;
    // One enable bit per byte lane
    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

    // Read data returned for any access that hits no address rule
    localparam logic [DATA_WIDTH-1:0] ERROR_RDATA = 32'hBADACCE5;

    //////////////////////////////////////////////////
    // Request, response and address rule
    //////////////////////////////////////////////////

    // Request from a master, also used towards every slave
    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } tcdm_req_t;

    // Response to a master, valid one cycle after its grant
    typedef struct packed {
        logic                  r_valid;
        // Raised together with r_valid when the access hit no rule
        logic                  r_opc;
        logic [DATA_WIDTH-1:0] r_rdata;
    } tcdm_rsp_t;

    // One address window, start inclusive and end exclusive.
    // Region 0 is the interleaved bank space, region k is contiguous slave k-1
    typedef struct packed {
        logic [7:0]            idx;
        logic [ADDR_WIDTH-1:0] start_addr;
        logic [ADDR_WIDTH-1:0] end_addr;
    } addr_rule_t;

endpackage

`default_nettype wire

// ==== design/addr_decoder.sv ====
/* Purely combinational address decode for one master.
   NR_BANKS must be a power of two; region numbers above NR_CONTIG are treated as unmapped. */

`timescale 1ns/1ps
`default_nettype none

module addr_decoder #(
    parameter int unsigned NR_BANKS  = 4,
    parameter int unsigned NR_CONTIG = 2,
    parameter int unsigned NR_RULES  = 3,
    // Banks first, then contiguous slaves, then the error responder
    localparam int unsigned NR_TARGETS = NR_BANKS + NR_CONTIG + 1,
    localparam int unsigned TGT_W      = $clog2(NR_TARGETS)
) (
    input  wire logic [interconnect_pkg::ADDR_WIDTH-1:0]  addr_i,
    input  wire interconnect_pkg::addr_rule_t [NR_RULES-1:0] rules_i,
    output logic [TGT_W-1:0]                               target_o
);

    // Number of byte-offset bits below the word address
    localparam int unsigned BYTE_OFS = $clog2(interconnect_pkg::BE_WIDTH);

    logic       hit;
    logic [7:0] hit_idx;
    logic [interconnect_pkg::ADDR_WIDTH-1:0] word_addr;

    // Word address, the low bits of which pick the interleaved bank
    assign word_addr = addr_i >> BYTE_OFS;

    // Walk the table from rule 0 upwards so the lowest matching rule wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int unsigned i = 0; i < NR_RULES; i++) begin
            if (!hit && (addr_i >= rules_i[i].start_addr) && (addr_i < rules_i[i].end_addr)) begin
                hit     = 1'b1;
                hit_idx = rules_i[i].idx;
            end
        end
    end

    // Turn the region number into a crossbar target index
    always_comb begin
        // Default is the error responder, which is always the last target
        target_o = TGT_W'(NR_TARGETS - 1);
        if (hit) begin
            if (hit_idx == 8'd0) begin
                // Interleaved space spreads consecutive words over the banks
                target_o = TGT_W'(word_addr % NR_BANKS);
            end else if (hit_idx <= NR_CONTIG) begin
                // Contiguous slave k-1 sits right after the banks
                target_o = TGT_W'(NR_BANKS + hit_idx - 1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
/* Round-robin arbiter for one crossbar target, grant is combinational.
   The priority pointer only moves when the target actually grants. */

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int unsigned NR_MASTERS = 2
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic [NR_MASTERS-1:0] req_i,
    input  wire logic                  gnt_en_i,
    output logic      [NR_MASTERS-1:0] gnt_o
);

    // A single master still needs a one-bit pointer
    localparam int unsigned PTR_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_next;
    logic [PTR_W-1:0] winner;
    logic             found;

    // First requester at or after the pointer, wrapping around once
    always_comb begin
        int unsigned cand;
        found  = 1'b0;
        winner = '0;
        for (int unsigned i = 0; i < NR_MASTERS; i++) begin
            cand = ptr_q + i;
            if (cand >= NR_MASTERS) begin
                cand = cand - NR_MASTERS;
            end
            if (!found && req_i[cand]) begin
                found  = 1'b1;
                winner = PTR_W'(cand);
            end
        end
    end

    // The target's own grant decides whether the winner is served this cycle
    always_comb begin
        gnt_o = '0;
        if (found && gnt_en_i) begin
            gnt_o[winner] = 1'b1;
        end
    end

    // Next round starts one past the master that was just served
    assign ptr_next = (winner == PTR_W'(NR_MASTERS - 1)) ? '0 : winner + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (|gnt_o) begin
            ptr_q <= ptr_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/tcdm_crossbar.sv ====
/* Full crossbar with one round-robin arbiter per target; every target answers one cycle
   after its grant. A target's grant must not depend combinationally on its request. */

`timescale 1ns/1ps
`default_nettype none

module tcdm_crossbar #(
    parameter int unsigned NR_MASTERS = 2,
    parameter int unsigned NR_TARGETS = 7,
    localparam int unsigned TGT_W     = $clog2(NR_TARGETS)
) (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_n_i,
    // Master side
    input  wire interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0] mst_req_i,
    input  wire logic [NR_MASTERS-1:0][TGT_W-1:0]     mst_target_i,
    output logic      [NR_MASTERS-1:0]                mst_gnt_o,
    output interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0] mst_rsp_o,
    // Target side
    output interconnect_pkg::tcdm_req_t [NR_TARGETS-1:0] tgt_req_o,
    input  wire logic [NR_TARGETS-1:0]                tgt_gnt_i,
    input  wire logic [NR_TARGETS-1:0][interconnect_pkg::DATA_WIDTH-1:0] tgt_rdata_i,
    input  wire logic [NR_TARGETS-1:0]                tgt_err_i
);

    // Per target, which masters want it this cycle
    logic [NR_TARGETS-1:0][NR_MASTERS-1:0] tgt_mreq;
    // Per target, the one-hot grant its arbiter gave out
    logic [NR_TARGETS-1:0][NR_MASTERS-1:0] arb_gnt;

    // Response tracking, one entry per master
    logic [NR_MASTERS-1:0]            rsp_valid_q;
    logic [NR_MASTERS-1:0][TGT_W-1:0] rsp_tgt_q;

    //////////////////////////////////////////////////
    // Request routing
    //////////////////////////////////////////////////

    // A master requests exactly the target its decoder picked
    always_comb begin
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                tgt_mreq[t][m] = mst_req_i[m].req && (mst_target_i[m] == TGT_W'(t));
            end
        end
    end

    // One arbiter per target, enabled by that target's grant
    for (genvar t = 0; t < NR_TARGETS; t++) begin : gen_arb
        rr_arbiter #(
            .NR_MASTERS (NR_MASTERS)
        ) rr_arbiter_inst (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .req_i    (tgt_mreq[t]),
            .gnt_en_i (tgt_gnt_i[t]),
            .gnt_o    (arb_gnt[t])
        );
    end

    // Steer the granted master's payload to each target.
    // With no grant the target sees an all-zero request, so req stays low
    always_comb begin
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            tgt_req_o[t] = '0;
            for (int unsigned m = 0; m < NR_MASTERS; m++) begin
                if (arb_gnt[t][m]) begin
                    tgt_req_o[t] = mst_req_i[m];
                end
            end
        end
    end

    // A master asks one target at a time, so at most one arbiter grants it
    always_comb begin
        mst_gnt_o = '0;
        for (int unsigned t = 0; t < NR_TARGETS; t++) begin
            mst_gnt_o = mst_gnt_o | arb_gnt[t];
        end
    end

    //////////////////////////////////////////////////
    // Response return path
    //////////////////////////////////////////////////

    // Every grant produces exactly one response in the next cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= '0;
        end else begin
            rsp_valid_q <= mst_gnt_o;
        end
    end

    // Remember which target answers each granted master
    always_ff @(posedge clk_i) begin
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            if (mst_gnt_o[m]) begin
                rsp_tgt_q[m] <= mst_target_i[m];
            end
        end
    end

    // Pick read data and error flag from the remembered target.
    // The error flag is masked so it never shows without r_valid
    always_comb begin
        for (int unsigned m = 0; m < NR_MASTERS; m++) begin
            mst_rsp_o[m].r_valid = rsp_valid_q[m];
            mst_rsp_o[m].r_opc   = rsp_valid_q[m] & tgt_err_i[rsp_tgt_q[m]];
            mst_rsp_o[m].r_rdata = tgt_rdata_i[rsp_tgt_q[m]];
        end
    end

endmodule

`default_nettype wire

// ==== design/error_slave.sv ====
/* Target for unmapped addresses; grants every request and flags it as an error.
   Reads and writes alike return ERROR_RDATA one cycle later, write data is dropped. */

`timescale 1ns/1ps
`default_nettype none

module error_slave (
    input  wire logic                              clk_i,
    input  wire logic                              rst_n_i,
    input  wire interconnect_pkg::tcdm_req_t       req_i,
    output logic                                   gnt_o,
    output logic [interconnect_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                                   err_o
);

    // An accepted request waiting for its error response
    logic pending_q;

    // Never back-pressure, an unmapped access must not stall its master
    assign gnt_o = 1'b1;

    // Since the grant is constant, every request is accepted
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= req_i.req;
        end
    end

    // Answer in the cycle after acceptance
    assign rdata_o = pending_q ? interconnect_pkg::ERROR_RDATA : '0;
    assign err_o   = pending_q;

endmodule

`default_nettype wire

// ==== design/soc_interconnect.sv ====
/* Memory interconnect top: per-master decode, one crossbar and an error responder.
   External slaves must return read data exactly one cycle after req and gnt are both high. */

`timescale 1ns/1ps
`default_nettype none

module soc_interconnect #(
    parameter int unsigned NR_MASTERS = 2,
    // Must be a power of two
    parameter int unsigned NR_BANKS   = 4,
    parameter int unsigned NR_CONTIG  = 2,
    parameter int unsigned NR_RULES   = 3
) (
    input  wire logic                                          clk_i,
    input  wire logic                                          rst_n_i,
    input  wire interconnect_pkg::addr_rule_t [NR_RULES-1:0]   addr_rules_i,
    // Masters
    input  wire interconnect_pkg::tcdm_req_t [NR_MASTERS-1:0]  mst_req_i,
    output logic [NR_MASTERS-1:0]                              mst_gnt_o,
    output interconnect_pkg::tcdm_rsp_t [NR_MASTERS-1:0]       mst_rsp_o,
    // Interleaved SRAM banks
    output interconnect_pkg::tcdm_req_t [NR_BANKS-1:0]         bank_req_o,
    input  wire logic [NR_BANKS-1:0]                           bank_gnt_i,
    input  wire logic [NR_BANKS-1:0][interconnect_pkg::DATA_WIDTH-1:0]  bank_rdata_i,
    // Contiguous slaves
    output interconnect_pkg::tcdm_req_t [NR_CONTIG-1:0]        contig_req_o,
    input  wire logic [NR_CONTIG-1:0]                          contig_gnt_i,
    input  wire logic [NR_CONTIG-1:0][interconnect_pkg::DATA_WIDTH-1:0] contig_rdata_i
);

    // Target order is banks, contiguous slaves, error responder
    localparam int unsigned NR_TARGETS = NR_BANKS + NR_CONTIG + 1;
    localparam int unsigned TGT_W      = $clog2(NR_TARGETS);

    logic [NR_MASTERS-1:0][TGT_W-1:0]                          mst_target;
    interconnect_pkg::tcdm_req_t [NR_TARGETS-1:0]              tgt_req;
    logic [NR_TARGETS-1:0]                                     tgt_gnt;
    logic [NR_TARGETS-1:0][interconnect_pkg::DATA_WIDTH-1:0]   tgt_rdata;
    logic [NR_TARGETS-1:0]                                     tgt_err;

    // Error responder outputs
    logic                                  err_gnt;
    logic [interconnect_pkg::DATA_WIDTH-1:0] err_rdata;
    logic                                  err_flag;

    //////////////////////////////////////////////////
    // Address decode, one per master
    //////////////////////////////////////////////////

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_dec
        addr_decoder #(
            .NR_BANKS  (NR_BANKS),
            .NR_CONTIG (NR_CONTIG),
            .NR_RULES  (NR_RULES)
        ) addr_decoder_inst (
            .addr_i   (mst_req_i[m].addr),
            .rules_i  (addr_rules_i),
            .target_o (mst_target[m])
        );
    end

    //////////////////////////////////////////////////
    // Crossbar and target wiring
    //////////////////////////////////////////////////

    // Banks take the low target slots, the error responder the top one
    assign tgt_gnt   = {err_gnt, contig_gnt_i, bank_gnt_i};
    assign tgt_rdata = {err_rdata, contig_rdata_i, bank_rdata_i};
    // External slaves never report errors
    assign tgt_err   = {err_flag, {(NR_BANKS + NR_CONTIG){1'b0}}};

    assign bank_req_o   = tgt_req[NR_BANKS-1:0];
    assign contig_req_o = tgt_req[NR_BANKS+NR_CONTIG-1:NR_BANKS];

    tcdm_crossbar #(
        .NR_MASTERS (NR_MASTERS),
        .NR_TARGETS (NR_TARGETS)
    ) tcdm_crossbar_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .mst_req_i    (mst_req_i),
        .mst_target_i (mst_target),
        .mst_gnt_o    (mst_gnt_o),
        .mst_rsp_o    (mst_rsp_o),
        .tgt_req_o    (tgt_req),
        .tgt_gnt_i    (tgt_gnt),
        .tgt_rdata_i  (tgt_rdata),
        .tgt_err_i    (tgt_err)
    );

    // Catches every access that matched no rule
    error_slave error_slave_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (tgt_req[NR_TARGETS-1]),
        .gnt_o   (err_gnt),
        .rdata_o (err_rdata),
        .err_o   (err_flag)
    );

endmodule

`default_nettype wire

// ==== test/tb_soc_interconnect.sv ====
/* Random testbench for soc_interconnect with 2 masters, 4 banks and 2 contiguous slaves.
   Memories outside the tested windows are never touched, since addresses stay in small windows. */

`timescale 1ns/1ps
`default_nettype none

module tb_soc_interconnect;

    localparam int unsigned NR_MASTERS = 2;
    localparam int unsigned NR_BANKS   = 4;
    localparam int unsigned NR_CONTIG  = 2;
    localparam int unsigned NR_RULES   = 3;
    localparam int unsigned NR_SLAVES  = NR_BANKS + NR_CONTIG;
    // The error responder is the last target
    localparam int unsigned ERR_TGT    = NR_SLAVES;
    localparam int unsigned MEM_BYTES  = 1024;
    localparam int unsigned RUN_CYCLES = 1500;
    localparam int unsigned DRAIN_MAX  = 50;

    logic clk_i;
    logic rst_n_i;
    interconnect_pkg::addr_rule_t [NR_RULES-1:0]   addr_rules_i;
    interconnect_pkg::tcdm_req_t  [NR_MASTERS-1:0] mst_req_i;
    logic [NR_MASTERS-1:0]                         mst_gnt_o;
    interconnect_pkg::tcdm_rsp_t  [NR_MASTERS-1:0] mst_rsp_o;
    interconnect_pkg::tcdm_req_t  [NR_BANKS-1:0]   bank_req_o;
    logic [NR_BANKS-1:0]                           bank_gnt_i;
    logic [NR_BANKS-1:0][31:0]                     bank_rdata_i;
    interconnect_pkg::tcdm_req_t  [NR_CONTIG-1:0]  contig_req_o;
    logic [NR_CONTIG-1:0]                          contig_gnt_i;
    logic [NR_CONTIG-1:0][31:0]                    contig_rdata_i;

    logic        stim_on;
    logic        contend;
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          contend_cycles;
    int          wait_cnt;

    // Slave memories with the banks first, next to the sparse reference memory
    logic [7:0] slave_mem [NR_SLAVES][MEM_BYTES];
    logic [7:0] ref_mem [int unsigned];

    // Handshakes seen at the falling edge drive the stimulus and the slave models
    logic [NR_MASTERS-1:0]       acc_seen;
    logic [NR_SLAVES-1:0]        slv_acc;
    interconnect_pkg::tcdm_req_t slv_pay [NR_SLAVES];

    // Response expected from each master's port in the next cycle
    logic [NR_MASTERS-1:0] exp_valid;
    logic [NR_MASTERS-1:0] exp_err;
    logic [NR_MASTERS-1:0] exp_chk;
    logic [31:0]           exp_data [NR_MASTERS];
    // Round-robin pointer per target
    int                    ptr_m [ERR_TGT+1];

    soc_interconnect #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS),
        .NR_CONTIG  (NR_CONTIG),
        .NR_RULES   (NR_RULES)
    ) soc_interconnect_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .addr_rules_i   (addr_rules_i),
        .mst_req_i      (mst_req_i),
        .mst_gnt_o      (mst_gnt_o),
        .mst_rsp_o      (mst_rsp_o),
        .bank_req_o     (bank_req_o),
        .bank_gnt_i     (bank_gnt_i),
        .bank_rdata_i   (bank_rdata_i),
        .contig_req_o   (contig_req_o),
        .contig_gnt_i   (contig_gnt_i),
        .contig_rdata_i (contig_rdata_i)
    );

    always #4 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int unsigned n, output logic [31:0] val);
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check(input logic [71:0] actual, input logic [71:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
        end
    endtask

    // Target of an address under the fixed rule table
    function automatic int target_of(input logic [31:0] a);
        if (a < 32'h1000) return (a >> 2) % NR_BANKS;
        if (a >= 32'h1000 && a < 32'h1400) return NR_BANKS;
        if (a >= 32'h2000 && a < 32'h2400) return NR_BANKS + 1;
        return ERR_TGT;
    endfunction

    // Power-up contents mix all four address bytes
    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3C;
    endfunction

    // Byte offset inside a slave model, where a bank drops its two bank-select bits
    function automatic int unsigned slave_index(input int t, input logic [31:0] a);
        if (t < NR_BANKS) return ((a >> 4) << 2) | (a & 3);
        return a & (MEM_BYTES - 1);
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return fill_byte(a);
    endfunction

    function automatic logic requests_pending();
        for (int m = 0; m < NR_MASTERS; m++) begin
            if (mst_req_i[m].req) return 1'b1;
        end
        return 1'b0;
    endfunction

    // Address in a bank window, a contiguous window or unmapped space.
    // Contention mode keeps every master on bank 0
    task automatic pick_addr(output logic [31:0] addr);
        logic [31:0] r;
        logic [31:0] sel;
        take_bits(2, sel);
        take_bits(7, r);
        if (contend) begin
            addr = 32'(r[5:0]) << 4;
        end else if (sel[1] == 1'b0) begin
            addr = (r[6] ? 32'h0F00 : 32'h0000) + (32'(r[5:0]) << 2);
        end else if (sel[0] == 1'b0) begin
            addr = (r[5] ? 32'h2000 : 32'h1000) + (32'(r[4:0]) << 2);
        end else begin
            case (r[5:4])
                2'd0:    addr = 32'h0000_1400;
                2'd1:    addr = 32'h0000_2400;
                2'd2:    addr = 32'h0000_3000;
                default: addr = 32'h8000_0000;
            endcase
            addr = addr + (32'(r[3:0]) << 2);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and slave models on the rising edge
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin
        logic [31:0] r;
        interconnect_pkg::tcdm_req_t nreq;
        if (rst_n_i) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                // A request not yet granted is held unchanged
                if (!mst_req_i[m].req || acc_seen[m]) begin
                    nreq = '0;
                    if (stim_on) begin
                        take_bits(2, r);
                        nreq.req = contend || (r[1:0] != 2'b00);
                        take_bits(5, r);
                        nreq.we = r[4];
                        nreq.be = r[3:0];
                        take_bits(32, r);
                        nreq.wdata = r;
                        pick_addr(nreq.addr);
                    end
                    mst_req_i[m] <= nreq;
                end
            end
            // Slaves grant three times in four and always while draining or contending
            for (int t = 0; t < NR_SLAVES; t++) begin
                take_bits(2, r);
                if (t < NR_BANKS) begin
                    bank_gnt_i[t] <= !stim_on || contend || (r[1:0] != 2'b00);
                end else begin
                    contig_gnt_i[t-NR_BANKS] <= !stim_on || contend || (r[1:0] != 2'b00);
                end
            end
        end
    end

    // Each slave returns the old word one cycle after its handshake
    always @(posedge clk_i) begin
        int unsigned idx;
        logic [31:0] word;
        for (int t = 0; t < NR_SLAVES; t++) begin
            if (slv_acc[t]) begin
                idx  = slave_index(t, slv_pay[t].addr);
                word = {slave_mem[t][idx+3], slave_mem[t][idx+2],
                        slave_mem[t][idx+1], slave_mem[t][idx]};
                if (t < NR_BANKS) begin
                    bank_rdata_i[t] <= word;
                end else begin
                    contig_rdata_i[t-NR_BANKS] <= word;
                end
                for (int j = 0; j < 4; j++) begin
                    if (slv_pay[t].we && slv_pay[t].be[j]) begin
                        slave_mem[t][idx+j] = slv_pay[t].wdata[8*j +: 8];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Reference model and checks on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk_i) begin
        logic [ERR_TGT:0]            tgt_gnt;
        logic [NR_MASTERS-1:0]       exp_gnt;
        interconnect_pkg::tcdm_req_t slv_req;
        int                          win [ERR_TGT+1];
        int                          t_of [NR_MASTERS];
        int                          cand;
        int                          nr_req;
        logic [31:0]                 a;
        if (!rst_n_i) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                check(mst_rsp_o[m].r_valid, 1'b0, $sformatf("master %0d r_valid in reset", m));
            end
            exp_valid = '0;
            acc_seen  = '0;
            slv_acc   = '0;
            for (int t = 0; t <= ERR_TGT; t++) begin
                ptr_m[t] = 0;
            end
        end else begin
            // Responses owed from the previous cycle
            for (int m = 0; m < NR_MASTERS; m++) begin
                check(mst_rsp_o[m].r_valid, exp_valid[m], $sformatf("master %0d r_valid", m));
                if (exp_valid[m]) begin
                    check(mst_rsp_o[m].r_opc, exp_err[m], $sformatf("master %0d r_opc", m));
                    if (exp_chk[m]) begin
                        check(mst_rsp_o[m].r_rdata, exp_data[m],
                              $sformatf("master %0d r_rdata", m));
                    end
                end
            end
            // Each target picks among its masters in round-robin order when its slave grants
            tgt_gnt = {1'b1, contig_gnt_i, bank_gnt_i};
            for (int m = 0; m < NR_MASTERS; m++) begin
                t_of[m] = target_of(mst_req_i[m].addr);
            end
            exp_gnt = '0;
            for (int t = 0; t <= ERR_TGT; t++) begin
                win[t] = -1;
                nr_req = 0;
                for (int i = 0; i < NR_MASTERS; i++) begin
                    cand = (ptr_m[t] + i) % NR_MASTERS;
                    if (mst_req_i[cand].req && t_of[cand] == t) begin
                        nr_req++;
                        if (win[t] < 0) win[t] = cand;
                    end
                end
                if (nr_req > 1 && tgt_gnt[t]) contend_cycles++;
                if (win[t] >= 0 && tgt_gnt[t]) begin
                    exp_gnt[win[t]] = 1'b1;
                    ptr_m[t]        = (win[t] + 1) % NR_MASTERS;
                end else begin
                    win[t] = -1;
                end
            end
            check(mst_gnt_o, exp_gnt, "master grant vector");
            // Only the winner's payload may appear, and only on its own slave port
            for (int t = 0; t < NR_SLAVES; t++) begin
                slv_req = (t < NR_BANKS) ? bank_req_o[t] : contig_req_o[t-NR_BANKS];
                check(slv_req.req, win[t] >= 0, $sformatf("slave %0d req", t));
                if (win[t] >= 0) begin
                    check(slv_req, mst_req_i[win[t]], $sformatf("slave %0d payload", t));
                end
                slv_acc[t] = slv_req.req && tgt_gnt[t];
                slv_pay[t] = slv_req;
            end
            // The master model follows the real grant, while the expected response
            // and the memory follow the grant the model predicts
            for (int m = 0; m < NR_MASTERS; m++) begin
                acc_seen[m]  = mst_req_i[m].req && mst_gnt_o[m];
                exp_valid[m] = mst_req_i[m].req && exp_gnt[m];
                if (exp_valid[m]) begin
                    a          = mst_req_i[m].addr;
                    exp_err[m] = (t_of[m] == ERR_TGT);
                    exp_chk[m] = exp_err[m] || !mst_req_i[m].we;
                    if (exp_err[m]) begin
                        exp_data[m] = interconnect_pkg::ERROR_RDATA;
                    end else begin
                        exp_data[m] = {ref_byte(a + 3), ref_byte(a + 2),
                                       ref_byte(a + 1), ref_byte(a)};
                    end
                    for (int j = 0; j < 4; j++) begin
                        if (!exp_err[m] && mst_req_i[m].we && mst_req_i[m].be[j]) begin
                            ref_mem[a + j] = mst_req_i[m].wdata[8*j +: 8];
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        mst_req_i      = '0;
        bank_gnt_i     = '0;
        bank_rdata_i   = '0;
        contig_gnt_i   = '0;
        contig_rdata_i = '0;
        addr_rules_i[0] = '{idx: 8'd0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
        addr_rules_i[1] = '{idx: 8'd1, start_addr: 32'h0000_1000, end_addr: 32'h0000_1400};
        addr_rules_i[2] = '{idx: 8'd2, start_addr: 32'h0000_2000, end_addr: 32'h0000_2400};
        stim_on        = 1'b0;
        contend        = 1'b0;
        lfsr_q         = 32'd97574;
        errors         = 0;
        checks         = 0;
        contend_cycles = 0;
        // Bank words sit at {index above the bank bits, bank, byte}
        for (int t = 0; t < NR_SLAVES; t++) begin
            for (int unsigned i = 0; i < MEM_BYTES; i++) begin
                if (t < NR_BANKS) begin
                    slave_mem[t][i] = fill_byte(((i >> 2) << 4) | (t << 2) | (i & 3));
                end else begin
                    slave_mem[t][i] = fill_byte((t == NR_BANKS ? 32'h1000 : 32'h2000) + i);
                end
            end
        end
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        stim_on = 1'b1;
        repeat (RUN_CYCLES) @(negedge clk_i);
        // Both masters fight for bank 0 with its grant held high
        contend = 1'b1;
        repeat (40) @(negedge clk_i);
        contend = 1'b0;
        repeat (RUN_CYCLES) @(negedge clk_i);
        stim_on  = 1'b0;
        wait_cnt = 0;
        while (requests_pending() && wait_cnt < DRAIN_MAX) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (requests_pending()) begin
            errors++;
            $display("Timeout: master requests were still not granted after %0d cycles",
                     DRAIN_MAX);
        end
        repeat (2) @(negedge clk_i);
        if (contend_cycles < 20) begin
            errors++;
            $display("Two masters rarely competed for one target (%0d cycles)", contend_cycles);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/interconnect_pkg.sv
design/addr_decoder.sv
design/rr_arbiter.sv
design/tcdm_crossbar.sv
design/error_slave.sv
design/soc_interconnect.sv
test/tb_soc_interconnect.sv
